// ==== rp_pkg.sv ====
//////////////////////////////////////////////////
// Shared types and constants of the analog path
// Sample, pin code and calibration widths
// Wishbone address and data words, region map
//////////////////////////////////////////////////

package rp_pkg;

  // Data path samples
  // Calibrated or converted sample, two's complement
  typedef logic signed [13:0] sample_t;
  // Raw pin code, offset binary with negative slope
  typedef logic        [13:0] raw_t;

  // Calibration coefficients
  // Gain, 16384 is unity
  typedef logic signed [15:0] cal_mul_t;
  // Offset in sample units
  typedef logic signed [13:0] cal_sum_t;

  // System bus words
  typedef logic [23:0] wb_adr_t;
  typedef logic [31:0] wb_dat_t;

  // Gain loaded at reset
  localparam cal_mul_t CAL_UNITY = 16'sd16384;

  // Housekeeping identification word
  localparam wb_dat_t HK_ID = 32'h52500001;

  // Regions in address bits 22 to 20
  localparam logic [2:0] REG_HK  = 3'd0;
  localparam logic [2:0] REG_CAL = 3'd1;

endpackage

// ==== rp_linear.sv ====
//////////////////////////////////////////////////
// Linear calibration pipeline, two stages
// Product, shift, offset and saturation
//////////////////////////////////////////////////

`timescale 1ns/1ns

module rp_linear import rp_pkg::*; #(
  // Gain and sample widths
  parameter int unsigned DWM = 16,
  parameter int unsigned DWS = 14
)(
  input  logic     adc_clk,
  input  logic     top_rst,
  input  sample_t  dat_i,
  input  cal_mul_t mul_i,
  input  cal_sum_t sum_i,
  output sample_t  dat_o
);

  // Full product, then unity gain scaling
  logic signed [DWS+DWM-1:0] prd;
  logic signed [DWS+1:0]     shf;
  // Two guard bits over the shifted product
  logic signed [DWS+2:0]     sum;
  logic                      fits;

  ///////////////////////////////////////////////////
  // Stage 1, multiply
  ///////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      prd <= '0;
    end else begin
      prd <= dat_i * mul_i;
    end
  end

  ///////////////////////////////////////////////////
  // Stage 2, shift, add offset, saturate
  ///////////////////////////////////////////////////

  // Arithmetic shift right by DWM-2
  assign shf = prd[DWS+DWM-1:DWM-2];
  assign sum = shf + sum_i;

  // In range when the upper bits are all copies of the sign
  assign fits = (&sum[DWS+2:DWS-1]) | ~(|sum[DWS+2:DWS-1]);

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dat_o <= '0;
    end else if (fits) begin
      dat_o <= sum[DWS-1:0];
    end else begin
      // Clip to the limit on the side of the sign
      dat_o <= {sum[DWS+2], {(DWS-1){~sum[DWS+2]}}};
    end
  end

endmodule

// ==== rp_adc_io.sv ====
//////////////////////////////////////////////////
// One ADC channel
// Pin register, code conversion, loop mux
// Calibration
//////////////////////////////////////////////////

`timescale 1ns/1ns

module rp_adc_io import rp_pkg::*; #(
  parameter int unsigned DWM = 16,
  parameter int unsigned DWS = 14
)(
  input  logic     adc_clk,
  input  logic     top_rst,
  // Pin and loop sources
  input  raw_t     raw_i,
  input  logic     loop_i,
  input  sample_t  loop_dat_i,
  // Calibration
  input  cal_mul_t mul_i,
  input  cal_sum_t sum_i,
  output sample_t  dat_o
);

  sample_t pin_dat;
  sample_t mux_dat;

  // Negative slope to two's complement, sign bit kept
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      pin_dat <= '0;
    end else begin
      pin_dat <= {raw_i[DWS-1], ~raw_i[DWS-2:0]};
    end
  end

  // Digital loop takes the calibrated DAC value
  assign mux_dat = loop_i ? loop_dat_i : pin_dat;

  rp_linear #(
    .DWM (DWM),
    .DWS (DWS)
  ) linear_adc (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (mux_dat),
    .mul_i   (mul_i),
    .sum_i   (sum_i),
    .dat_o   (dat_o)
  );

endmodule

// ==== rp_dac_io.sv ====
//////////////////////////////////////////////////
// One DAC channel
// Calibration, pin register with code conversion
//////////////////////////////////////////////////

`timescale 1ns/1ns

module rp_dac_io import rp_pkg::*; #(
  parameter int unsigned DWM = 16,
  parameter int unsigned DWS = 14
)(
  input  logic     adc_clk,
  input  logic     top_rst,
  // Generator samples
  input  sample_t  dat_i,
  // Calibration
  input  cal_mul_t mul_i,
  input  cal_sum_t sum_i,
  // Calibrated value for the loop, pin code
  output sample_t  cal_o,
  output raw_t     raw_o
);

  rp_linear #(
    .DWM (DWM),
    .DWS (DWS)
  ) linear_dac (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (dat_i),
    .mul_i   (mul_i),
    .sum_i   (sum_i),
    .dat_o   (cal_o)
  );

  // Output register
  // two's complement back to negative slope
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      raw_o <= '0;
    end else begin
      raw_o <= {cal_o[DWS-1], ~cal_o[DWS-2:0]};
    end
  end

endmodule

// ==== rp_bus_decoder.sv ====
//////////////////////////////////////////////////
// Wishbone classic region decoder
// Slave strobes, read data and ack multiplexer
// Local ack for unmapped regions
//////////////////////////////////////////////////

`timescale 1ns/1ns

module rp_bus_decoder import rp_pkg::*; (
  input  logic    adc_clk,
  input  logic    top_rst,
  // Master side
  input  logic    wb_cyc_i,
  input  logic    wb_stb_i,
  input  wb_adr_t wb_adr_i,
  // Slave strobes
  output logic    hk_stb_o,
  output logic    cal_stb_o,
  // Slave responses
  input  wb_dat_t hk_dat_i,
  input  logic    hk_ack_i,
  input  wb_dat_t cal_dat_i,
  input  logic    cal_ack_i,
  // Back to master
  output wb_dat_t wb_dat_o,
  output logic    wb_ack_o
);

  logic [2:0] region;
  logic       bus_req;
  logic       nul_sel;
  logic       nul_ack;

  // Region number from the upper address bits
  assign region  = wb_adr_i[22:20];
  assign bus_req = wb_cyc_i & wb_stb_i;

  assign hk_stb_o  = bus_req & (region == REG_HK);
  assign cal_stb_o = bus_req & (region == REG_CAL);
  assign nul_sel   = (region != REG_HK) && (region != REG_CAL);

  // Unmapped region, ack once so the master never hangs
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      nul_ack <= 1'b0;
    end else begin
      nul_ack <= bus_req & nul_sel & ~nul_ack;
    end
  end

  // Response of the addressed slave
  always_comb begin
    case (region)
      REG_HK: begin
        wb_dat_o = hk_dat_i;
        wb_ack_o = hk_ack_i;
      end
      REG_CAL: begin
        wb_dat_o = cal_dat_i;
        wb_ack_o = cal_ack_i;
      end
      default: begin
        // Nothing here, reads as zero
        wb_dat_o = '0;
        wb_ack_o = nul_ack;
      end
    endcase
  end

endmodule

// ==== rp_hk.sv ====
//////////////////////////////////////////////////
// Housekeeping register slave
// ID word, digital loop switch, LED register
//////////////////////////////////////////////////

`timescale 1ns/1ns

module rp_hk import rp_pkg::*; #(
  parameter int unsigned N_CH = 2
)(
  input  logic       adc_clk,
  input  logic       top_rst,
  // Bus slave
  input  logic       stb_i,
  input  logic       we_i,
  input  wb_adr_t    adr_i,
  input  wb_dat_t    dat_i,
  output wb_dat_t    dat_o,
  output logic       ack_o,
  // Configuration
  output logic       digital_loop_o,
  output logic [7:0] led_o
);

  logic [2:0] word;

  // Word offset inside the region
  assign word = adr_i[4:2];

  // Single cycle ack, writes land on the same edge
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      ack_o          <= 1'b0;
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end else begin
      ack_o <= stb_i & ~ack_o;
      if (stb_i && we_i && !ack_o) begin
        case (word)
          3'd1:    digital_loop_o <= dat_i[0];
          3'd2:    led_o          <= dat_i[7:0];
          default: ;
        endcase
      end
    end
  end

  // Readback, address held by the master until ack
  always_comb begin
    case (word)
      3'd0:    dat_o = HK_ID;
      3'd1:    dat_o = {31'b0, digital_loop_o};
      3'd2:    dat_o = {24'b0, led_o};
      // Channel count, read only
      3'd3:    dat_o = wb_dat_t'(N_CH);
      default: dat_o = '0;
    endcase
  end

endmodule

// ==== rp_calib.sv ====
//////////////////////////////////////////////////
// Calibration register slave
// Gain and offset per ADC and DAC channel
// Sign-extended readback
//////////////////////////////////////////////////

`timescale 1ns/1ns

module rp_calib import rp_pkg::*; #(
  parameter int unsigned N_CH = 2
)(
  input  logic                      adc_clk,
  input  logic                      top_rst,
  // Bus slave
  input  logic                      stb_i,
  input  logic                      we_i,
  input  wb_adr_t                   adr_i,
  input  wb_dat_t                   dat_i,
  output wb_dat_t                   dat_o,
  output logic                      ack_o,
  // Coefficients to the data path
  output cal_mul_t [N_CH-1:0]       adc_mul_o,
  output cal_sum_t [N_CH-1:0]       adc_sum_o,
  output cal_mul_t [N_CH-1:0]       dac_mul_o,
  output cal_sum_t [N_CH-1:0]       dac_sum_o
);

  // Word offset fields
  // bit 4 selects DAC, bit 3 the channel, bit 2 offset over gain
  logic is_dac;
  logic is_sum;
  int   ch;

  assign is_dac = adr_i[4];
  assign is_sum = adr_i[2];
  assign ch     = int'(adr_i[3]);

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      ack_o <= 1'b0;
      // Unity gain, no offset
      for (int i = 0; i < N_CH; i++) begin
        adc_mul_o[i] <= CAL_UNITY;
        adc_sum_o[i] <= '0;
        dac_mul_o[i] <= CAL_UNITY;
        dac_sum_o[i] <= '0;
      end
    end else begin
      ack_o <= stb_i & ~ack_o;
      if (stb_i && we_i && !ack_o) begin
        for (int i = 0; i < N_CH; i++) begin
          if (i == ch) begin
            case ({is_dac, is_sum})
              2'b00: adc_mul_o[i] <= dat_i[15:0];
              2'b01: adc_sum_o[i] <= dat_i[13:0];
              2'b10: dac_mul_o[i] <= dat_i[15:0];
              2'b11: dac_sum_o[i] <= dat_i[13:0];
            endcase
          end
        end
      end
    end
  end

  // Readback with sign extension
  always_comb begin
    dat_o = '0;
    for (int i = 0; i < N_CH; i++) begin
      if (i == ch) begin
        case ({is_dac, is_sum})
          2'b00: dat_o = {{16{adc_mul_o[i][15]}}, adc_mul_o[i]};
          2'b01: dat_o = {{18{adc_sum_o[i][13]}}, adc_sum_o[i]};
          2'b10: dat_o = {{16{dac_mul_o[i][15]}}, dac_mul_o[i]};
          2'b11: dat_o = {{18{dac_sum_o[i][13]}}, dac_sum_o[i]};
        endcase
      end
    end
  end

endmodule

// ==== rp_top.sv ====
//////////////////////////////////////////////////
// Analog data path top level
// Bus decoder, register slaves, channel blocks
//////////////////////////////////////////////////

`timescale 1ns/1ns

module rp_top import rp_pkg::*; #(
  parameter int unsigned N_CH = 2,
  parameter int unsigned DWM  = 16,
  parameter int unsigned DWS  = 14
)(
  input  logic                 adc_clk,
  input  logic                 top_rst,
  // Wishbone master port
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  wb_adr_t              wb_adr_i,
  input  wb_dat_t              wb_dat_i,
  output wb_dat_t              wb_dat_o,
  output logic                 wb_ack_o,
  // Converters
  input  raw_t    [N_CH-1:0]   adc_raw_i,
  input  sample_t [N_CH-1:0]   dac_dat_i,
  output sample_t [N_CH-1:0]   adc_dat_o,
  output raw_t    [N_CH-1:0]   dac_raw_o,
  output logic    [7:0]        led_o
);

  ///////////////////////////////////////////////////
  // Local signals
  ///////////////////////////////////////////////////

  // Slave strobes and responses
  logic     hk_stb;
  logic     cal_stb;
  wb_dat_t  hk_dat;
  wb_dat_t  cal_dat;
  logic     hk_ack;
  logic     cal_ack;

  logic     digital_loop;

  // Calibration coefficients
  cal_mul_t [N_CH-1:0] adc_mul;
  cal_sum_t [N_CH-1:0] adc_sum;
  cal_mul_t [N_CH-1:0] dac_mul;
  cal_sum_t [N_CH-1:0] dac_sum;

  // Calibrated DAC values for the loop
  sample_t  [N_CH-1:0] dac_cal;

  ///////////////////////////////////////////////////
  // Bus and registers
  ///////////////////////////////////////////////////

  rp_bus_decoder bus_dec (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_adr_i  (wb_adr_i),
    .hk_stb_o  (hk_stb),
    .cal_stb_o (cal_stb),
    .hk_dat_i  (hk_dat),
    .hk_ack_i  (hk_ack),
    .cal_dat_i (cal_dat),
    .cal_ack_i (cal_ack),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o)
  );

  rp_hk #(
    .N_CH (N_CH)
  ) hk (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .stb_i          (hk_stb),
    .we_i           (wb_we_i),
    .adr_i          (wb_adr_i),
    .dat_i          (wb_dat_i),
    .dat_o          (hk_dat),
    .ack_o          (hk_ack),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  rp_calib #(
    .N_CH (N_CH)
  ) calib (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .stb_i     (cal_stb),
    .we_i      (wb_we_i),
    .adr_i     (wb_adr_i),
    .dat_i     (wb_dat_i),
    .dat_o     (cal_dat),
    .ack_o     (cal_ack),
    .adc_mul_o (adc_mul),
    .adc_sum_o (adc_sum),
    .dac_mul_o (dac_mul),
    .dac_sum_o (dac_sum)
  );

  ///////////////////////////////////////////////////
  // Channels
  ///////////////////////////////////////////////////

  for (genvar i = 0; i < N_CH; i++) begin : g_ch

    // DAC first, its calibrated value feeds the ADC loop
    rp_dac_io #(
      .DWM (DWM),
      .DWS (DWS)
    ) dac_io (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (dac_dat_i[i]),
      .mul_i   (dac_mul[i]),
      .sum_i   (dac_sum[i]),
      .cal_o   (dac_cal[i]),
      .raw_o   (dac_raw_o[i])
    );

    rp_adc_io #(
      .DWM (DWM),
      .DWS (DWS)
    ) adc_io (
      .adc_clk    (adc_clk),
      .top_rst    (top_rst),
      .raw_i      (adc_raw_i[i]),
      .loop_i     (digital_loop),
      .loop_dat_i (dac_cal[i]),
      .mul_i      (adc_mul[i]),
      .sum_i      (adc_sum[i]),
      .dat_o      (adc_dat_o[i])
    );

  end : g_ch

endmodule

// ==== tb_rp_top.sv ====
//////////////////////////////////////////////////
// Testbench for the analog data path top level
// Wishbone tasks, calibration reference model
// Expected value queue, checker, watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_rp_top import rp_pkg::*; ();

  localparam int          N_CH        = 2;
  localparam int          STREAM_LEN  = 150;
  localparam int          N_STREAMS   = 6;
  localparam int          N_BUS       = 120;
  localparam int          TEST_CYCLES = N_STREAMS * (STREAM_LEN + 8) + N_BUS * 4;
  localparam int          SAT_HI      = 8191;
  localparam int          SAT_LO      = -8192;
  localparam logic [31:0] SEED        = 32'h7a63954c;
  localparam wb_adr_t     HK_BASE     = {1'b0, REG_HK, 20'h0};
  localparam wb_adr_t     CAL_BASE    = {1'b0, REG_CAL, 20'h0};
  // Region 3 has no slave
  localparam wb_adr_t     NUL_BASE    = 24'h300000;

  // One expected output value, due at cycle stamp
  typedef struct packed {
    int          stamp;
    logic        is_dac;
    logic        ch;
    logic [13:0] val;
  } exp_t;

  logic                adc_clk;
  logic                top_rst;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  wb_adr_t             wb_adr;
  wb_dat_t             wb_wdat;
  wb_dat_t             wb_rdat;
  logic                wb_ack;
  raw_t    [N_CH-1:0]  adc_raw;
  sample_t [N_CH-1:0]  dac_dat;
  sample_t [N_CH-1:0]  adc_dat;
  raw_t    [N_CH-1:0]  dac_raw;
  logic    [7:0]       led;

  // Shadow of the calibration registers
  cal_mul_t amul_sh [N_CH];
  cal_sum_t asum_sh [N_CH];
  cal_mul_t dmul_sh [N_CH];
  cal_sum_t dsum_sh [N_CH];

  exp_t exp_q [$];
  int   cycle;
  int   hi_hits;
  int   lo_hits;

  rp_top #(
    .N_CH (N_CH)
  ) dut (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .wb_we_i   (wb_we),
    .wb_adr_i  (wb_adr),
    .wb_dat_i  (wb_wdat),
    .wb_dat_o  (wb_rdat),
    .wb_ack_o  (wb_ack),
    .adc_raw_i (adc_raw),
    .dac_dat_i (dac_dat),
    .adc_dat_o (adc_dat),
    .dac_raw_o (dac_raw),
    .led_o     (led)
  );

  // 8 ns clock
  initial adc_clk = 1'b0;
  always #4 adc_clk = ~adc_clk;

  always @(posedge adc_clk) begin
    cycle <= cycle + 1;
  end

  ///////////////////////////////////////////////////
  // Reference model
  ///////////////////////////////////////////////////

  // Gain in units of 2^-14, then offset, then clip to 14 bits
  function automatic sample_t linear_ref(sample_t x, cal_mul_t m, cal_sum_t s);
    longint acc;
    acc = (longint'(x) * longint'(m)) >>> 14;
    acc = acc + longint'(s);
    if (acc > SAT_HI) begin
      acc = SAT_HI;
    end else if (acc < SAT_LO) begin
      acc = SAT_LO;
    end
    return sample_t'(acc);
  endfunction

  // Pin code rule, sign bit kept and the other 13 bits inverted
  function automatic sample_t raw_to_sample(raw_t r);
    return sample_t'(r ^ 14'h1fff);
  endfunction

  function automatic raw_t sample_to_raw(sample_t d);
    return raw_t'(d) ^ 14'h1fff;
  endfunction

  ///////////////////////////////////////////////////
  // Reporting
  ///////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check(input string name, input wb_dat_t got, input wb_dat_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  ///////////////////////////////////////////////////
  // Wishbone master
  ///////////////////////////////////////////////////

  task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                            output wb_dat_t rdat);
    int waited;
    @(posedge adc_clk);
    #1;
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = wdat;
    waited  = 0;
    // Hold the request until the slave acks
    do begin
      @(posedge adc_clk);
      #1;
      waited++;
    end while (!wb_ack && waited < 16);
    if (!wb_ack) begin
      fail_run($sformatf("no bus ack for address %h after %0d cycles", adr, waited));
    end
    rdat   = wb_rdat;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_reg(input wb_adr_t adr, input wb_dat_t dat);
    wb_dat_t unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic read_reg(input wb_adr_t adr, output wb_dat_t dat);
    bus_access(1'b0, adr, '0, dat);
  endtask

  // Readback is sign-extended
  task automatic check_cal(input int ch);
    wb_dat_t rd;
    wb_adr_t base;
    base = CAL_BASE + wb_adr_t'(ch * 8);
    read_reg(base, rd);
    check($sformatf("adc gain %0d", ch), rd, int'(amul_sh[ch]));
    read_reg(base + 24'h4, rd);
    check($sformatf("adc offset %0d", ch), rd, int'(asum_sh[ch]));
    read_reg(base + 24'h10, rd);
    check($sformatf("dac gain %0d", ch), rd, int'(dmul_sh[ch]));
    read_reg(base + 24'h14, rd);
    check($sformatf("dac offset %0d", ch), rd, int'(dsum_sh[ch]));
  endtask

  task automatic load_cal(input int ch, input cal_mul_t am, input cal_sum_t as,
                          input cal_mul_t dm, input cal_sum_t ds);
    wb_adr_t base;
    base = CAL_BASE + wb_adr_t'(ch * 8);
    write_reg(base, int'(am));
    write_reg(base + 24'h4, int'(as));
    write_reg(base + 24'h10, int'(dm));
    write_reg(base + 24'h14, int'(ds));
    amul_sh[ch] = am;
    asum_sh[ch] = as;
    dmul_sh[ch] = dm;
    dsum_sh[ch] = ds;
    check_cal(ch);
  endtask

  ///////////////////////////////////////////////////
  // Sample streams and comparison
  ///////////////////////////////////////////////////

  task automatic push_exp(input int stamp, input logic is_dac, input int ch,
                          input logic [13:0] val);
    exp_t e;
    e.stamp  = stamp;
    e.is_dac = is_dac;
    e.ch     = ch[0];
    e.val    = val;
    exp_q.push_back(e);
  endtask

  task automatic count_limits(input sample_t v);
    if (v == sample_t'(SAT_HI)) hi_hits++;
    if (v == sample_t'(SAT_LO)) lo_hits++;
  endtask

  // New random sample on every channel each cycle
  task automatic run_stream(input int n, input logic loop);
    sample_t dcal [N_CH];
    sample_t ain;
    sample_t aout;
    repeat (n) begin
      @(posedge adc_clk);
      #1;
      // DAC entries first so the queue stays sorted by stamp
      for (int c = 0; c < N_CH; c++) begin
        adc_raw[c] = raw_t'($urandom);
        dac_dat[c] = sample_t'($urandom);
        dcal[c]    = linear_ref(dac_dat[c], dmul_sh[c], dsum_sh[c]);
        count_limits(dcal[c]);
        push_exp(cycle + 3, 1'b1, c, sample_to_raw(dcal[c]));
      end
      for (int c = 0; c < N_CH; c++) begin
        ain  = loop ? dcal[c] : raw_to_sample(adc_raw[c]);
        aout = linear_ref(ain, amul_sh[c], asum_sh[c]);
        count_limits(aout);
        push_exp(loop ? cycle + 4 : cycle + 3, 1'b0, c, aout);
      end
    end
    while (exp_q.size() != 0) @(posedge adc_clk);
  endtask

  // Outputs are stable at the falling edge
  always @(negedge adc_clk) begin : compare
    exp_t e;
    while (exp_q.size() != 0 && exp_q[0].stamp <= cycle) begin
      e = exp_q.pop_front();
      if (e.is_dac) begin
        check($sformatf("dac_raw_o[%0d]", e.ch), {18'b0, dac_raw[e.ch]}, {18'b0, e.val});
      end else begin
        check($sformatf("adc_dat_o[%0d]", e.ch), {18'b0, adc_dat[e.ch]}, {18'b0, e.val});
      end
    end
  end

  initial begin : watchdog
    repeat (2000 + TEST_CYCLES) @(posedge adc_clk);
    fail_run("watchdog expired before the tests finished");
  end

  ///////////////////////////////////////////////////
  // Test sequence
  ///////////////////////////////////////////////////

  initial begin : main
    wb_dat_t rd;
    void'($urandom(SEED));
    cycle     = 0;
    hi_hits   = 0;
    lo_hits   = 0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_wdat   = '0;
    adc_raw   = '0;
    dac_dat   = '0;
    for (int c = 0; c < N_CH; c++) begin
      amul_sh[c] = CAL_UNITY;
      asum_sh[c] = '0;
      dmul_sh[c] = CAL_UNITY;
      dsum_sh[c] = '0;
    end
    top_rst = 1'b1;
    repeat (4) @(posedge adc_clk);
    #1;
    top_rst = 1'b0;

    // Reset values
    check("wb_ack_o", {31'b0, wb_ack}, 32'h0);
    read_reg(HK_BASE, rd);
    check("hk id", rd, HK_ID);
    read_reg(HK_BASE + 24'h4, rd);
    check("digital loop", rd, 32'h0);
    read_reg(HK_BASE + 24'h8, rd);
    check("led register", rd, 32'h0);
    check("led_o", {24'b0, led}, 32'h0);
    // Channel count word
    read_reg(HK_BASE + 24'hc, rd);
    check("channel count", rd, N_CH);
    for (int c = 0; c < N_CH; c++) check_cal(c);

    // Unity calibration, pure code conversion
    run_stream(STREAM_LEN, 1'b0);

    // Random calibration
    repeat (3) begin
      for (int c = 0; c < N_CH; c++) begin
        load_cal(c, cal_mul_t'($urandom), cal_sum_t'($urandom),
                 cal_mul_t'($urandom), cal_sum_t'($urandom));
      end
      run_stream(STREAM_LEN, 1'b0);
    end

    // Near double gain with extreme offsets drives both limits
    for (int c = 0; c < N_CH; c++) begin
      load_cal(c, 16'sh7fff, cal_sum_t'(SAT_HI), 16'sh7fff, cal_sum_t'(SAT_LO));
    end
    run_stream(STREAM_LEN, 1'b0);
    if (hi_hits == 0 || lo_hits == 0) begin
      fail_run("calibrated samples never reached both saturation limits");
    end

    // Digital loop, ADC pins ignored
    for (int c = 0; c < N_CH; c++) begin
      load_cal(c, cal_mul_t'($urandom), cal_sum_t'($urandom),
               cal_mul_t'($urandom), cal_sum_t'($urandom));
    end
    write_reg(HK_BASE + 24'h4, 32'h1);
    read_reg(HK_BASE + 24'h4, rd);
    check("digital loop", rd, 32'h1);
    run_stream(STREAM_LEN, 1'b1);
    write_reg(HK_BASE + 24'h4, 32'h0);

    // LEDs and an unmapped region
    write_reg(HK_BASE + 24'h8, 32'h000000a5);
    check("led_o", {24'b0, led}, 32'h000000a5);
    read_reg(HK_BASE + 24'h8, rd);
    check("led register", rd, 32'h000000a5);
    write_reg(NUL_BASE, 32'hffffffff);
    read_reg(NUL_BASE + 24'h4, rd);
    check("unmapped read", rd, 32'h0);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== list.f ====
rp_pkg.sv
rp_linear.sv
rp_adc_io.sv
rp_dac_io.sv
rp_bus_decoder.sv
rp_hk.sv
rp_calib.sv
rp_top.sv
tb_rp_top.sv

// ==== Bender.yml ====
package:
  name: rp_analog

sources:
  - rp_pkg.sv
  - rp_linear.sv
  - rp_adc_io.sv
  - rp_dac_io.sv
  - rp_bus_decoder.sv
  - rp_hk.sv
  - rp_calib.sv
  - rp_top.sv
  - target: simulation
    files:
      - tb_rp_top.sv
